// File: design/display_pkg.sv
////////////////////
// Register map, field sizes and raster size of the display controller
// Shared structs and the bus word union
////////////////////

package display_pkg;

  // Host bus widths
  localparam int ADDR_W = 8;
  localparam int DATA_W = 16;

  // Register addresses, everything above reads as zero
  localparam int MAIN_CTRL_ADDR = 0;
  localparam int X_POS_ADDR     = 1;
  localparam int Y_POS_ADDR     = 2;
  localparam int X_OFFSET_ADDR  = 3;
  localparam int Y_OFFSET_ADDR  = 4;
  // Number of mapped registers, width of the one-hot select
  localparam int NUM_REGS       = 5;

  // Stored offset bits, low byte plus two bits of the high byte
  localparam int X_OFFSET_SIZE = 10;
  localparam int Y_OFFSET_SIZE = 10;

  // Scaled-down raster, columns by lines
  localparam int SCAN_W = 32;
  localparam int SCAN_H = 24;

  // Coordinate width, wraps at 1024
  localparam int COORD_W = 10;

  // MAIN_CTRL layout, bit 0 at the bottom
  typedef struct packed {
    logic [2:0] reserved;
    // Self-clearing screenshot request
    logic       shot_req;
    logic [1:0] video_mode;
    // Host may access video memory
    logic       vram_access;
    // Display output running
    logic       out_en;
  } main_ctrl_t;

  // Control view of a bus word, MAIN_CTRL sits in the low byte
  typedef struct packed {
    logic [7:0] unused;
    main_ctrl_t main;
  } ctrl_word_t;

  // One bus word, read as plain bits or as the control view
  typedef union packed {
    logic [DATA_W-1:0] raw;
    ctrl_word_t        ctrl;
  } reg_word_u;

  // Decoded host write towards the register file
  typedef struct packed {
    logic [NUM_REGS-1:0] addr_sel;
    logic [1:0]          byte_en;
    reg_word_u           data;
  } reg_write_t;

  // Register file contents seen by the other blocks
  typedef struct packed {
    main_ctrl_t               ctrl;
    logic [X_OFFSET_SIZE-1:0] x_offset;
    logic [Y_OFFSET_SIZE-1:0] y_offset;
  } ctrl_state_t;

  // Raw scan position
  typedef struct packed {
    logic [COORD_W-1:0] x_pos;
    logic [COORD_W-1:0] y_pos;
  } scan_pos_t;

  // Scan output with scrolled coordinate and frame pulses
  typedef struct packed {
    scan_pos_t          pos;
    logic [COORD_W-1:0] pix_x;
    logic [COORD_W-1:0] pix_y;
    logic               frame_start;
    logic               shot;
  } pixel_t;

endpackage

// File: design/host_port.sv
////////////////////
// Host bus front end
// Address decode, write strobe and registered read mux
////////////////////

`timescale 1ns/1ps

module host_port (
  input  logic                             clk,
  input  logic                             rst_n,
  // Access strobes from the host
  input  logic                             en,
  input  logic                             rd,
  input  logic                             wr,
  // Byte lane enables, bit 0 is the low byte
  input  logic [1:0]                       be,
  input  logic [display_pkg::ADDR_W-1:0]   addr,
  input  display_pkg::reg_word_u           wdata,
  // Current register contents and scan position for reads
  input  display_pkg::ctrl_state_t         ctrl_state,
  input  display_pkg::scan_pos_t           pos,
  // Decoded write towards the register file
  output display_pkg::reg_write_t          wr_req,
  output logic                             wr_strobe,
  output logic [display_pkg::DATA_W-1:0]   rdata
);

  // One-hot register select, all zero for unmapped addresses
  logic [display_pkg::NUM_REGS-1:0] addr_sel;
  // Read accepted in this cycle
  logic                             rd_strobe;
  // Read mux result before the output register
  display_pkg::reg_word_u           rd_word;

  // Address decode
  always_comb
  begin
    for (int i = 0; i < display_pkg::NUM_REGS; i++)
    begin
      addr_sel[i] = (addr == display_pkg::ADDR_W'(i));
    end
  end

  // A read strobe together with wr turns the access into a read
  assign wr_strobe = en & wr & ~rd;
  assign rd_strobe = en & rd;

  // Write request carries the word untouched, lanes picked downstream
  always_comb
  begin
    wr_req.addr_sel = addr_sel;
    wr_req.byte_en  = be;
    wr_req.data     = wdata;
  end

  // Read mux over the five registers
  always_comb
  begin
    rd_word.raw = '0;
    if (addr_sel[display_pkg::MAIN_CTRL_ADDR])
    begin
      // Control byte goes out through the control view
      rd_word.ctrl.main = ctrl_state.ctrl;
    end
    if (addr_sel[display_pkg::X_POS_ADDR])
    begin
      rd_word.raw = display_pkg::DATA_W'(pos.x_pos);
    end
    if (addr_sel[display_pkg::Y_POS_ADDR])
    begin
      rd_word.raw = display_pkg::DATA_W'(pos.y_pos);
    end
    if (addr_sel[display_pkg::X_OFFSET_ADDR])
    begin
      // Offsets zero-extended to the bus width
      rd_word.raw = display_pkg::DATA_W'(ctrl_state.x_offset);
    end
    if (addr_sel[display_pkg::Y_OFFSET_ADDR])
    begin
      rd_word.raw = display_pkg::DATA_W'(ctrl_state.y_offset);
    end
  end

  // Read data valid for one cycle after the sampling edge
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rdata <= '0;
    end
    else if (rd_strobe)
    begin
      rdata <= rd_word.raw;
    end
    else
    begin
      // Bus idles at zero between reads
      rdata <= '0;
    end
  end

endmodule

// File: design/control_regs.sv
////////////////////
// Writable control registers
// MAIN_CTRL and the two display offsets with byte lane writes
////////////////////

`timescale 1ns/1ps

module control_regs (
  input  logic                      clk,
  input  logic                      rst_n,
  // Decoded host write and its strobe
  input  display_pkg::reg_write_t   wr_req,
  input  logic                      wr_strobe,
  // Screenshot taken, clears the request
  input  logic                      shot_done,
  output display_pkg::ctrl_state_t  ctrl_state
);

  // Register storage
  display_pkg::main_ctrl_t                 main_ctrl;
  logic [display_pkg::X_OFFSET_SIZE-1:0]   x_offset;
  logic [display_pkg::Y_OFFSET_SIZE-1:0]   y_offset;

  // Per-register write enables
  logic                                    ctrl_wr;
  logic                                    x_wr;
  logic                                    y_wr;
  // Masked write value for MAIN_CTRL
  display_pkg::main_ctrl_t                 ctrl_wdata;
  // Offset words after the lane merge
  logic [display_pkg::DATA_W-1:0]          x_next;
  logic [display_pkg::DATA_W-1:0]          y_next;

  // Replace only the enabled byte lanes of a word
  function automatic logic [display_pkg::DATA_W-1:0] merge_lanes(
    input logic [display_pkg::DATA_W-1:0] old_word,
    input logic [display_pkg::DATA_W-1:0] new_word,
    input logic [1:0]                     lanes
  );
    logic [display_pkg::DATA_W-1:0] result;
    result = old_word;
    if (lanes[0])
    begin
      result[7:0] = new_word[7:0];
    end
    if (lanes[1])
    begin
      result[15:8] = new_word[15:8];
    end
    return result;
  endfunction

  // MAIN_CTRL lives in the low lane only
  assign ctrl_wr = wr_strobe & wr_req.addr_sel[display_pkg::MAIN_CTRL_ADDR]
                 & wr_req.byte_en[0];
  assign x_wr    = wr_strobe & wr_req.addr_sel[display_pkg::X_OFFSET_ADDR];
  assign y_wr    = wr_strobe & wr_req.addr_sel[display_pkg::Y_OFFSET_ADDR];

  // Control view of the word, reserved bits never stored
  always_comb
  begin
    ctrl_wdata          = wr_req.data.ctrl.main;
    ctrl_wdata.reserved = '0;
  end

  // Unused high bits drop out when the result is sliced
  assign x_next = merge_lanes(display_pkg::DATA_W'(x_offset), wr_req.data.raw,
                              wr_req.byte_en);
  assign y_next = merge_lanes(display_pkg::DATA_W'(y_offset), wr_req.data.raw,
                              wr_req.byte_en);

  // MAIN_CTRL, a host write beats the screenshot clear
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      main_ctrl <= '0;
    end
    else if (ctrl_wr)
    begin
      main_ctrl <= ctrl_wdata;
    end
    else if (shot_done)
    begin
      main_ctrl.shot_req <= 1'b0;
    end
  end

  // Display offsets
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      x_offset <= '0;
      y_offset <= '0;
    end
    else
    begin
      if (x_wr)
        x_offset <= x_next[display_pkg::X_OFFSET_SIZE-1:0];
      if (y_wr)
        y_offset <= y_next[display_pkg::Y_OFFSET_SIZE-1:0];
    end
  end

  // Visible right after the write edge
  always_comb
  begin
    ctrl_state.ctrl     = main_ctrl;
    ctrl_state.x_offset = x_offset;
    ctrl_state.y_offset = y_offset;
  end

endmodule

// File: design/scan_counter.sv
////////////////////
// Raster scan counter
// Position counters, scrolled coordinate and frame pulses
////////////////////

`timescale 1ns/1ps

module scan_counter (
  input  logic                      clk,
  input  logic                      rst_n,
  // Enable, screenshot request and offsets from the register file
  input  display_pkg::ctrl_state_t  ctrl_state,
  output display_pkg::pixel_t       pixel,
  // One-cycle pulse, clears the screenshot request
  output logic                      shot_done
);

  // Registered raster position
  logic [display_pkg::COORD_W-1:0] x_pos;
  logic [display_pkg::COORD_W-1:0] y_pos;
  // Position for the next cycle while running
  logic [display_pkg::COORD_W-1:0] x_next;
  logic [display_pkg::COORD_W-1:0] y_next;
  // End of line and end of frame
  logic                            x_last;
  logic                            y_last;
  // Next position is the frame origin
  logic                            at_origin;
  // Pulses registered with the position
  logic                            frame_start;
  logic                            shot;

  assign x_last = (x_pos == display_pkg::COORD_W'(display_pkg::SCAN_W - 1));
  assign y_last = (y_pos == display_pkg::COORD_W'(display_pkg::SCAN_H - 1));

  // Column advances every clock, line on column wrap
  always_comb
  begin
    x_next = x_pos + display_pkg::COORD_W'(1);
    y_next = y_pos;
    if (x_last)
    begin
      x_next = '0;
      if (y_last)
        y_next = '0;
      else
        y_next = y_pos + display_pkg::COORD_W'(1);
    end
  end

  assign at_origin = (x_next == '0) && (y_next == '0);

  // Position and pulses, held at the origin while output is off
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      x_pos       <= '0;
      y_pos       <= '0;
      frame_start <= 1'b0;
      shot        <= 1'b0;
    end
    else if (ctrl_state.ctrl.out_en)
    begin
      x_pos       <= x_next;
      y_pos       <= y_next;
      // Pulse lands in the cycle that shows 0,0
      frame_start <= at_origin;
      // Screenshot rides on the frame start
      shot        <= at_origin & ctrl_state.ctrl.shot_req;
    end
    else
    begin
      x_pos       <= '0;
      y_pos       <= '0;
      frame_start <= 1'b0;
      shot        <= 1'b0;
    end
  end

  // Request cleared once the shot pulse is out
  assign shot_done = shot;

  // Scrolled coordinate from the registered position and live offsets
  always_comb
  begin
    pixel.pos.x_pos   = x_pos;
    pixel.pos.y_pos   = y_pos;
    // Sum wraps at 1024
    pixel.pix_x       = x_pos + display_pkg::COORD_W'(ctrl_state.x_offset);
    pixel.pix_y       = y_pos + display_pkg::COORD_W'(ctrl_state.y_offset);
    pixel.frame_start = frame_start;
    pixel.shot        = shot;
  end

endmodule

// File: design/display_ctrl_top.sv
////////////////////
// Display controller top level
// Host port, register file and scan counter
////////////////////

`timescale 1ns/1ps

module display_ctrl_top (
  input  logic                            clk,
  input  logic                            rst_n,
  // Host memory-style port
  input  logic                            en,
  input  logic                            rd,
  input  logic                            wr,
  input  logic [1:0]                      be,
  input  logic [display_pkg::ADDR_W-1:0]  addr,
  input  display_pkg::reg_word_u          wdata,
  output logic [display_pkg::DATA_W-1:0]  rdata,
  // Register contents and scan output
  output display_pkg::ctrl_state_t        ctrl_state,
  output display_pkg::pixel_t             pixel
);

  // Host port to register file
  display_pkg::reg_write_t wr_req;
  logic                    wr_strobe;
  // Scan counter back to the register file
  logic                    shot_done;

  host_port u_host_port (
    .clk        (clk),
    .rst_n      (rst_n),
    .en         (en),
    .rd         (rd),
    .wr         (wr),
    .be         (be),
    .addr       (addr),
    .wdata      (wdata),
    .ctrl_state (ctrl_state),
    // Raw position for the X_POS and Y_POS reads
    .pos        (pixel.pos),
    .wr_req     (wr_req),
    .wr_strobe  (wr_strobe),
    .rdata      (rdata)
  );

  control_regs u_control_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_req     (wr_req),
    .wr_strobe  (wr_strobe),
    .shot_done  (shot_done),
    .ctrl_state (ctrl_state)
  );

  scan_counter u_scan_counter (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl_state (ctrl_state),
    .pixel      (pixel),
    .shot_done  (shot_done)
  );

endmodule

// File: bench/display_ctrl_checks.svh
////////////////////
// Compare tasks for the read word, the register state and the scan output
////////////////////

`ifndef DISPLAY_CTRL_CHECKS_SVH
`define DISPLAY_CTRL_CHECKS_SVH

// Host read data word
task automatic check_word(
  input string                          name,
  input logic [display_pkg::DATA_W-1:0] got,
  input logic [display_pkg::DATA_W-1:0] exp
);
  if (got !== exp)
  begin
    $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    stop_on_error();
  end
endtask

// Register file contents
task automatic check_ctrl(
  input string                    name,
  input display_pkg::ctrl_state_t got,
  input display_pkg::ctrl_state_t exp
);
  if (got !== exp)
  begin
    $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    // Got and expected per field
    $display("   ctrl %h/%h x_offset %h/%h y_offset %h/%h", got.ctrl, exp.ctrl,
             got.x_offset, exp.x_offset, got.y_offset, exp.y_offset);
    stop_on_error();
  end
endtask

// Scan position, scrolled coordinate and pulses
task automatic check_pixel(
  input string               name,
  input display_pkg::pixel_t got,
  input display_pkg::pixel_t exp
);
  if (got !== exp)
  begin
    $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    $display("   pos %h/%h pix_x %h/%h pix_y %h/%h frame_start %h/%h shot %h/%h",
             got.pos, exp.pos, got.pix_x, exp.pix_x, got.pix_y, exp.pix_y,
             got.frame_start, exp.frame_start, got.shot, exp.shot);
    stop_on_error();
  end
endtask

`endif

// File: bench/display_ctrl_tb.sv
////////////////////
// Display controller testbench
// Clock, reset, stimulus, reference model, compare process, watchdog
////////////////////

`timescale 1ns/1ps

module display_ctrl_tb;

  // One frame of the scaled raster
  localparam int FRAME_CYCLES = display_pkg::SCAN_W * display_pkg::SCAN_H;
  localparam int NUM_RANDOM   = 200;
  localparam int NUM_SCROLL   = 100;
  // Bus cycles of all sections, two frames of scan reads and three of shot wait
  localparam int PLANNED_CYCLES = 300 + 2 * NUM_RANDOM + 8 * NUM_SCROLL + 5 * FRAME_CYCLES;

  logic                           clk;
  logic                           rst_n;
  logic                           en;
  logic                           rd;
  logic                           wr;
  logic [1:0]                     be;
  logic [display_pkg::ADDR_W-1:0] addr;
  display_pkg::reg_word_u         wdata;
  logic [display_pkg::DATA_W-1:0] rdata;
  display_pkg::ctrl_state_t       ctrl_state;
  display_pkg::pixel_t            pixel;

  // Reference model state
  display_pkg::ctrl_state_t       m_state;
  display_pkg::scan_pos_t         m_pos;
  logic                           m_fs;
  logic                           m_shot;
  logic [display_pkg::DATA_W-1:0] m_rdata;
  // Screenshot pulses seen so far
  int                             shot_count = 0;

  display_ctrl_top dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .en         (en),
    .rd         (rd),
    .wr         (wr),
    .be         (be),
    .addr       (addr),
    .wdata      (wdata),
    .rdata      (rdata),
    .ctrl_state (ctrl_state),
    .pixel      (pixel)
  );

  task automatic stop_on_error();
    $display("ERRORS FOUND");
    $fatal(1, "first mismatch, run stopped");
  endtask

  `include "display_ctrl_checks.svh"

  // Expected read word for an address
  function automatic logic [display_pkg::DATA_W-1:0] expect_read(
    input logic [display_pkg::ADDR_W-1:0] a,
    input display_pkg::ctrl_state_t       st,
    input display_pkg::scan_pos_t         p
  );
    logic [display_pkg::DATA_W-1:0] word;
    word = '0;
    case (int'(a))
      display_pkg::MAIN_CTRL_ADDR: word[7:0] = st.ctrl;
      display_pkg::X_POS_ADDR:     word[display_pkg::COORD_W-1:0] = p.x_pos;
      display_pkg::Y_POS_ADDR:     word[display_pkg::COORD_W-1:0] = p.y_pos;
      display_pkg::X_OFFSET_ADDR:  word[display_pkg::X_OFFSET_SIZE-1:0] = st.x_offset;
      display_pkg::Y_OFFSET_ADDR:  word[display_pkg::Y_OFFSET_SIZE-1:0] = st.y_offset;
      default:                     word = '0;
    endcase
    return word;
  endfunction

  // Register contents after a host write
  function automatic display_pkg::ctrl_state_t apply_write(
    input display_pkg::ctrl_state_t       st,
    input logic [display_pkg::ADDR_W-1:0] a,
    input logic [1:0]                     lanes,
    input logic [display_pkg::DATA_W-1:0] d
  );
    display_pkg::ctrl_state_t res;
    res = st;
    case (int'(a))
      display_pkg::MAIN_CTRL_ADDR:
      begin
        // Top three bits reserved, always zero
        if (lanes[0])
          res.ctrl = display_pkg::main_ctrl_t'(d[7:0] & 8'h1f);
      end
      display_pkg::X_OFFSET_ADDR:
      begin
        if (lanes[0])
          res.x_offset[7:0] = d[7:0];
        if (lanes[1])
          res.x_offset[display_pkg::X_OFFSET_SIZE-1:8] = d[display_pkg::X_OFFSET_SIZE-1:8];
      end
      display_pkg::Y_OFFSET_ADDR:
      begin
        if (lanes[0])
          res.y_offset[7:0] = d[7:0];
        if (lanes[1])
          res.y_offset[display_pkg::Y_OFFSET_SIZE-1:8] = d[display_pkg::Y_OFFSET_SIZE-1:8];
      end
      default:
      begin
      end
    endcase
    return res;
  endfunction

  // Expected scan output, scroll sums wrap at 1024
  function automatic display_pkg::pixel_t expect_pixel(
    input display_pkg::scan_pos_t   p,
    input display_pkg::ctrl_state_t st,
    input logic                     fs,
    input logic                     shot
  );
    display_pkg::pixel_t px;
    int                  sum_x;
    int                  sum_y;
    sum_x          = (int'(p.x_pos) + int'(st.x_offset)) % (1 << display_pkg::COORD_W);
    sum_y          = (int'(p.y_pos) + int'(st.y_offset)) % (1 << display_pkg::COORD_W);
    px.pos         = p;
    px.pix_x       = display_pkg::COORD_W'(sum_x);
    px.pix_y       = display_pkg::COORD_W'(sum_y);
    px.frame_start = fs;
    px.shot        = shot;
    return px;
  endfunction

  task automatic write_reg(input int a, input logic [15:0] d, input logic [1:0] lanes);
    @(posedge clk);
    en        <= 1'b1;
    rd        <= 1'b0;
    wr        <= 1'b1;
    addr      <= display_pkg::ADDR_W'(a);
    be        <= lanes;
    wdata.raw <= d;
  endtask

  task automatic read_reg(input int a);
    @(posedge clk);
    en        <= 1'b1;
    rd        <= 1'b1;
    // wr together with rd is still a read
    wr        <= 1'($urandom);
    addr      <= display_pkg::ADDR_W'(a);
    be        <= 2'($urandom);
    wdata.raw <= 16'($urandom);
  endtask

  task automatic idle_bus(input int cycles);
    repeat (cycles)
    begin
      @(posedge clk);
      // Strobes without en do nothing
      en <= 1'b0;
      rd <= 1'($urandom);
      wr <= 1'($urandom);
    end
  endtask

  // Waits at falling edges until the shot pulse shows up
  task automatic wait_for_shot(input int limit);
    int waited;
    waited = 0;
    do
    begin
      @(negedge clk);
      waited++;
    end
    while (!pixel.shot && waited < limit);
    if (!pixel.shot)
    begin
      $display("no screenshot pulse within %0d cycles", limit);
      stop_on_error();
    end
  endtask

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Reference model, inputs seen before the stimulus updates them
  always @(posedge clk or negedge rst_n)
  begin : reference_model
    display_pkg::ctrl_state_t next_state;
    display_pkg::scan_pos_t   next_pos;
    int                       col;
    int                       row;
    if (!rst_n)
    begin
      m_state = '0;
      m_pos   = '0;
      m_fs    = 1'b0;
      m_shot  = 1'b0;
      m_rdata = '0;
    end
    else
    begin
      if (en && rd)
        m_rdata = expect_read(addr, m_state, m_pos);
      else
        m_rdata = '0;
      next_state = m_state;
      // Last cycle's shot clears the request, a host write overrides it
      if (m_shot)
        next_state.ctrl.shot_req = 1'b0;
      if (en && wr && !rd)
        next_state = apply_write(next_state, addr, be, wdata.raw);
      if (m_state.ctrl.out_en)
      begin
        col = int'(m_pos.x_pos) + 1;
        row = int'(m_pos.y_pos);
        if (col == display_pkg::SCAN_W)
        begin
          col = 0;
          row = (row + 1) % display_pkg::SCAN_H;
        end
        next_pos.x_pos = display_pkg::COORD_W'(col);
        next_pos.y_pos = display_pkg::COORD_W'(row);
        m_fs           = (col == 0) && (row == 0);
        m_shot         = m_fs && m_state.ctrl.shot_req;
      end
      else
      begin
        next_pos = '0;
        m_fs     = 1'b0;
        m_shot   = 1'b0;
      end
      m_state = next_state;
      m_pos   = next_pos;
    end
  end

  // Outputs compared at the falling edge, every cycle out of reset
  always @(negedge clk)
  begin : compare
    if (rst_n === 1'b1)
    begin
      check_word("rdata", rdata, m_rdata);
      check_ctrl("ctrl_state", ctrl_state, m_state);
      check_pixel("pixel", pixel, expect_pixel(m_pos, m_state, m_fs, m_shot));
      if (pixel.shot)
        shot_count++;
    end
  end

  initial
  begin : watchdog
    repeat (PLANNED_CYCLES + 4 * FRAME_CYCLES) @(posedge clk);
    $display("run did not finish within %0d cycles", PLANNED_CYCLES + 4 * FRAME_CYCLES);
    $display("ERRORS FOUND");
    $fatal(1, "watchdog timeout");
  end

  initial
  begin : stimulus
    int a;
    int base;
    rst_n = 1'b0;
    en    = 1'b0;
    rd    = 1'b0;
    wr    = 1'b0;
    be    = '0;
    addr  = '0;
    wdata = '0;
    void'($urandom(29874));
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // Reset values, then unmapped addresses
    for (int i = 0; i < 16; i++)
      read_reg(i);
    for (int i = 0; i < 8; i++)
      read_reg(8 + int'($urandom % 248));

    // Random lane writes with read-back
    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      a = int'($urandom % 8);
      write_reg(a, 16'($urandom), 2'($urandom));
      read_reg(a);
    end

    // Two frames from the origin with position reads
    write_reg(display_pkg::MAIN_CTRL_ADDR, 16'h0000, 2'b01);
    idle_bus(2);
    write_reg(display_pkg::MAIN_CTRL_ADDR, 16'h0001, 2'b01);
    for (int i = 0; i < 2 * FRAME_CYCLES + 8; i++)
    begin
      if (i % 3 == 2)
        idle_bus(1);
      else
        read_reg(i % 3 == 0 ? display_pkg::X_POS_ADDR : display_pkg::Y_POS_ADDR);
    end

    // Offset writes mid-frame
    for (int i = 0; i < NUM_SCROLL; i++)
    begin
      a = ($urandom % 2 == 0) ? display_pkg::X_OFFSET_ADDR : display_pkg::Y_OFFSET_ADDR;
      write_reg(a, 16'($urandom), 2'($urandom));
      read_reg(a);
      idle_bus(int'($urandom % 6));
    end

    // One screenshot at the next frame start, then request reads back clear
    base = shot_count;
    write_reg(display_pkg::MAIN_CTRL_ADDR, 16'h0011, 2'b01);
    idle_bus(1);
    wait_for_shot(2 * FRAME_CYCLES);
    // Runs past the following frame start so a repeated pulse is counted
    idle_bus(FRAME_CYCLES + 2);
    if (shot_count - base != 1)
    begin
      $display("expected one screenshot pulse, saw %0d", shot_count - base);
      stop_on_error();
    end
    read_reg(display_pkg::MAIN_CTRL_ADDR);
    idle_bus(1);
    @(negedge clk);
    check_word("rdata", rdata, 16'h0001);

    // Output off mid-frame, request without output gives no pulse
    idle_bus(100);
    write_reg(display_pkg::MAIN_CTRL_ADDR, 16'h0000, 2'b11);
    for (int i = 0; i < 64; i++)
      read_reg(i % 2 == 0 ? display_pkg::X_POS_ADDR : display_pkg::Y_POS_ADDR);
    base = shot_count;
    write_reg(display_pkg::MAIN_CTRL_ADDR, 16'h0010, 2'b01);
    for (int i = 0; i < 64; i++)
      read_reg(i % 2 == 0 ? display_pkg::X_POS_ADDR : display_pkg::MAIN_CTRL_ADDR);
    idle_bus(2);
    if (shot_count != base)
    begin
      $display("screenshot pulse with the output disabled");
      stop_on_error();
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: sim.f
+incdir+bench
design/display_pkg.sv
design/host_port.sv
design/control_regs.sv
design/scan_counter.sv
design/display_ctrl_top.sv
bench/display_ctrl_tb.sv

// File: Makefile
# Verilator build and run of the display controller testbench

TOP := display_ctrl_tb

.PHONY: all compile run clean

all: run

# Builds obj_dir/display_ctrl_tb from the file list
compile:
	verilator --binary --timing --top-module $(TOP) -f sim.f -o $(TOP)

# Exit status is nonzero when the testbench stops with $fatal
run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
